//--- common/pipeCtrlPkg.sv
/*
 * Shared definitions for the pipeline control unit: opcodes, ALU and bypass
 * codes, instruction word views, control bundles and register-use rules.
 */
package pipeCtrlPkg;

	////////////////////////////////////////
	// opcodes
	localparam logic [3:0] opLoad  = 4'b0000;
	localparam logic [3:0] opStore = 4'b0010;
	localparam logic [3:0] opAdd   = 4'b0100;
	localparam logic [3:0] opSub   = 4'b0110;
	localparam logic [3:0] opNand  = 4'b1000;
	localparam logic [3:0] opBz    = 4'b0101;
	localparam logic [3:0] opBnz   = 4'b1001;
	localparam logic [3:0] opBpz   = 4'b1101;
	localparam logic [3:0] opStop  = 4'b0001;
	localparam logic [3:0] opNop   = 4'b1010;
	localparam logic [2:0] opOri   = 3'b111; // only low 3 bits, imm above
	localparam logic [2:0] opShift = 3'b011; // bit 3 is part of the shift field

	localparam logic [7:0] nopWord = {4'b0000, opNop}; // bubble word

	// alu operation codes
	localparam logic [2:0] aluAdd   = 3'b000;
	localparam logic [2:0] aluSub   = 3'b001;
	localparam logic [2:0] aluOri   = 3'b010;
	localparam logic [2:0] aluNand  = 3'b011;
	localparam logic [2:0] aluShift = 3'b100;

	// bypass selects
	localparam logic [1:0] bypNone = 2'd0;
	localparam logic [1:0] bypAlu  = 2'd1; // producer's alu result
	localparam logic [1:0] bypMem  = 2'd2; // producer's loaded data

	////////////////////////////////////////
	// instruction word, three ways to read it
	typedef struct packed {
		logic [1:0] rx;
		logic [1:0] ry;
		logic [3:0] op;
	} regForm_t;

	typedef struct packed {
		logic [4:0] imm;
		logic [2:0] op3;
	} oriForm_t;

	typedef struct packed {
		logic [3:0] offset; // pc relative
		logic [3:0] op;
	} brForm_t;

	typedef union packed {
		regForm_t regForm;
		oriForm_t oriForm;
		brForm_t  brForm;
	} instr_t;

	// execute stage controls
	typedef struct packed {
		logic       memRead;
		logic       memWrite;
		logic       mdrLoad;
		logic       flagWrite;
		logic       aluIn1Sel; // 0 reg, 1 pc
		logic [2:0] aluIn2Sel;
		logic [2:0] aluOp;
	} exCtrl_t;

	// writeback controls
	typedef struct packed {
		logic rfWrite;
		logic regIn; // 0 alu result, 1 memory data
		logic rwSel; // write reg from ori rule
	} wbCtrl_t;

	typedef struct packed {
		logic [1:0] aluIn1Sel;
		logic [1:0] aluIn2Sel;
		logic [1:0] memDataSel;
		logic [1:0] memAddrSel;
		logic [1:0] r1InSel;
		logic [1:0] r2InSel;
	} bypassSel_t;

	// source operands read by one instruction
	typedef struct packed {
		logic       use1;
		logic [1:0] reg1;
		logic       use2;
		logic [1:0] reg2;
	} srcOps_t;

	////////////////////////////////////////
	// classification helpers
	function automatic logic isOri(instr_t i);
		return i.oriForm.op3 == opOri;
	endfunction

	function automatic logic isShift(instr_t i);
		return i.oriForm.op3 == opShift;
	endfunction

	function automatic logic isAluReg(instr_t i); // add, sub, nand
		return (i.regForm.op == opAdd) || (i.regForm.op == opSub) || (i.regForm.op == opNand);
	endfunction

	function automatic logic isBranch(instr_t i);
		return (i.brForm.op == opBz) || (i.brForm.op == opBnz) || (i.brForm.op == opBpz);
	endfunction

	function automatic logic writesReg(instr_t i);
		return isAluReg(i) || isShift(i) || isOri(i) || (i.regForm.op == opLoad);
	endfunction

	function automatic logic [1:0] destReg(instr_t i, logic [1:0] oriReg);
		return isOri(i) ? oriReg : i.regForm.rx; // ori has no reg field
	endfunction

	function automatic srcOps_t srcReg(instr_t i, logic [1:0] oriReg);
		srcOps_t s;
		s = '0;
		if (isAluReg(i) || (i.regForm.op == opStore))
		begin
			s.use1 = 1'b1; // store data lives in rx
			s.reg1 = i.regForm.rx;
			s.use2 = 1'b1; // store address lives in ry
			s.reg2 = i.regForm.ry;
		end
		else if (isShift(i))
		begin
			s.use1 = 1'b1;
			s.reg1 = i.regForm.rx;
		end
		else if (isOri(i))
		begin
			s.use1 = 1'b1;
			s.reg1 = oriReg;
		end
		else if (i.regForm.op == opLoad)
		begin
			s.use2 = 1'b1; // address only
			s.reg2 = i.regForm.ry;
		end
		return s;
	endfunction

endpackage

//--- hdl/instrPipe.sv
/*
 * Instruction slots for register fetch, execute and writeback.
 * Bubbles are NOP words, inserted on squash and on stop.
 */
`timescale 1ns/1ps

module instrPipe (
	input  logic                clock,
	input  logic                reset,
	input  pipeCtrlPkg::instr_t fetchInstr,
	input  logic                squash,  // taken branch in execute
	input  logic                stopped, // sticky halt
	output pipeCtrlPkg::instr_t irRf,
	output pipeCtrlPkg::instr_t irEx,
	output pipeCtrlPkg::instr_t irWb
);

	pipeCtrlPkg::instr_t rfNext; // what lands in irRf
	pipeCtrlPkg::instr_t exNext; // what lands in irEx

	// younger two slots get bubbles behind a taken branch
	assign rfNext = squash ? pipeCtrlPkg::nopWord : fetchInstr;
	assign exNext = squash ? pipeCtrlPkg::nopWord : irRf;

	////////////////////////////////////////
	// slot registers
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			irRf <= pipeCtrlPkg::nopWord;
			irEx <= pipeCtrlPkg::nopWord;
			irWb <= pipeCtrlPkg::nopWord;
		end
		else if (stopped)
		begin
			// halted, drain everything
			irRf <= pipeCtrlPkg::nopWord;
			irEx <= pipeCtrlPkg::nopWord;
			irWb <= pipeCtrlPkg::nopWord;
		end
		else
		begin
			irRf <= rfNext;
			irEx <= exNext;
			irWb <= irEx; // branch itself still retires
		end
	end

endmodule

//--- execute/executeDecode.sv
/*
 * Execute stage decode: datapath controls, branch resolution from the
 * N and Z flags, and the sticky stop latch.
 */
`timescale 1ns/1ps

module executeDecode (
	input  logic                 clock,
	input  logic                 reset,
	input  pipeCtrlPkg::instr_t  irEx,
	input  logic                 n,
	input  logic                 z,
	output pipeCtrlPkg::exCtrl_t exCtrl,
	output logic                 pcSel,   // to pc mux
	output logic                 squash,  // to instruction slots
	output logic                 stopped
);

	logic [3:0] op;        // 4-bit view of the opcode
	logic       isBr;
	logic       condMet;   // flag test for this branch type
	logic       offsetZero;
	logic       stopHit;   // STOP or branch to self
	pipeCtrlPkg::exCtrl_t dec;

	assign op         = irEx.regForm.op;
	assign isBr       = pipeCtrlPkg::isBranch(irEx);
	assign offsetZero = irEx.brForm.offset == 4'd0;

	////////////////////////////////////////
	// control decode
	always_comb
	begin
		dec = '0;
		if (op == pipeCtrlPkg::opLoad)
		begin
			dec.memRead = 1'b1;
			dec.mdrLoad = 1'b1; // capture read data
		end
		else if (op == pipeCtrlPkg::opStore)
			dec.memWrite = 1'b1;
		else if (pipeCtrlPkg::isAluReg(irEx))
		begin
			dec.aluIn2Sel = 3'd0; // register operand
			dec.flagWrite = 1'b1;
			case (op)
				pipeCtrlPkg::opAdd: dec.aluOp = pipeCtrlPkg::aluAdd;
				pipeCtrlPkg::opSub: dec.aluOp = pipeCtrlPkg::aluSub;
				default:            dec.aluOp = pipeCtrlPkg::aluNand;
			endcase
		end
		else if (pipeCtrlPkg::isShift(irEx))
		begin
			dec.aluIn2Sel = 3'd4; // shift amount field
			dec.aluOp     = pipeCtrlPkg::aluShift;
			dec.flagWrite = 1'b1;
		end
		else if (pipeCtrlPkg::isOri(irEx))
		begin
			dec.aluIn2Sel = 3'd3; // zero-extended imm
			dec.aluOp     = pipeCtrlPkg::aluOri;
			dec.flagWrite = 1'b1;
		end
		else if (isBr)
		begin
			dec.aluIn1Sel = 1'b1; // pc
			dec.aluIn2Sel = 3'd2; // branch offset
			dec.aluOp     = pipeCtrlPkg::aluAdd;
		end
	end

	// nothing leaves execute once halted
	assign exCtrl = stopped ? '0 : dec;

	////////////////////////////////////////
	// branch resolution
	always_comb
	begin
		case (op)
			pipeCtrlPkg::opBz:  condMet = z;
			pipeCtrlPkg::opBnz: condMet = !z;
			pipeCtrlPkg::opBpz: condMet = !n;
			default:            condMet = 1'b0;
		endcase
	end

	assign pcSel  = !stopped && isBr && condMet && !offsetZero;
	assign squash = pcSel; // same event, separate consumer

	// stop latch, sticky until reset
	assign stopHit = (op == pipeCtrlPkg::opStop) || (isBr && offsetZero);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			stopped <= 1'b0;
		else if (stopHit)
			stopped <= 1'b1;
	end

endmodule

//--- hdl/writebackDecode.sv
/*
 * Writeback decode, register file write controls for the oldest slot.
 */
`timescale 1ns/1ps

module writebackDecode (
	input  pipeCtrlPkg::instr_t  irWb,
	output pipeCtrlPkg::wbCtrl_t wbCtrl
);

	logic isLoad; // result comes from memory
	logic isOri;  // destination fixed by ori rule

	assign isLoad = irWb.regForm.op == pipeCtrlPkg::opLoad;
	assign isOri  = pipeCtrlPkg::isOri(irWb);

	// same rule the bypass logic uses for producers
	assign wbCtrl.rfWrite = pipeCtrlPkg::writesReg(irWb);
	assign wbCtrl.regIn   = isLoad; // mdr instead of alu out
	assign wbCtrl.rwSel   = isOri;

endmodule

//--- hazard/bypassSelect.sv
/*
 * Bypass select generation. The writeback slot is the producer; the
 * execute slot consumes at distance one, register fetch at distance two.
 */
`timescale 1ns/1ps

module bypassSelect #(
	parameter logic [1:0] oriReg = 2'd1 // register implied by ORI
) (
	input  pipeCtrlPkg::instr_t     irRf,
	input  pipeCtrlPkg::instr_t     irEx,
	input  pipeCtrlPkg::instr_t     irWb,
	output pipeCtrlPkg::bypassSel_t bypass
);

	////////////////////////////////////////
	// producer side
	logic       prodWrites; // irWb writes a register
	logic [1:0] prodDest;   // and this is the one
	logic [1:0] prodCode;   // alu or mem source

	assign prodWrites = pipeCtrlPkg::writesReg(irWb);
	assign prodDest   = pipeCtrlPkg::destReg(irWb, oriReg);
	assign prodCode   = (irWb.regForm.op == pipeCtrlPkg::opLoad) ?
		pipeCtrlPkg::bypMem : pipeCtrlPkg::bypAlu;

	////////////////////////////////////////
	// consumer operands
	pipeCtrlPkg::srcOps_t exSrc; // distance one
	pipeCtrlPkg::srcOps_t rfSrc; // distance two

	assign exSrc = pipeCtrlPkg::srcReg(irEx, oriReg);
	assign rfSrc = pipeCtrlPkg::srcReg(irRf, oriReg);

	logic ex1Hit;
	logic ex2Hit;
	logic rf1Hit;
	logic rf2Hit;

	assign ex1Hit = prodWrites && exSrc.use1 && (exSrc.reg1 == prodDest);
	assign ex2Hit = prodWrites && exSrc.use2 && (exSrc.reg2 == prodDest);
	assign rf1Hit = prodWrites && rfSrc.use1 && (rfSrc.reg1 == prodDest);
	assign rf2Hit = prodWrites && rfSrc.use2 && (rfSrc.reg2 == prodDest);

	// which execute-stage mux the operand feeds
	logic exAluType;
	logic exStore;
	logic exLoad;

	assign exAluType = pipeCtrlPkg::isAluReg(irEx) || pipeCtrlPkg::isShift(irEx) ||
		pipeCtrlPkg::isOri(irEx);
	assign exStore   = irEx.regForm.op == pipeCtrlPkg::opStore;
	assign exLoad    = irEx.regForm.op == pipeCtrlPkg::opLoad;

	////////////////////////////////////////
	// select assembly
	always_comb
	begin
		bypass = '0; // everything bypNone by default

		// distance one, alu inputs or memory ports
		if (exAluType)
		begin
			if (ex1Hit)
				bypass.aluIn1Sel = prodCode;
			if (ex2Hit)
				bypass.aluIn2Sel = prodCode;
		end
		else if (exStore)
		begin
			if (ex1Hit)
				bypass.memDataSel = prodCode; // value being stored
			if (ex2Hit)
				bypass.memAddrSel = prodCode;
		end
		else if (exLoad)
		begin
			if (ex2Hit)
				bypass.memAddrSel = prodCode; // load address
		end

		// distance two, register read outputs
		if (rf1Hit)
			bypass.r1InSel = prodCode;
		if (rf2Hit)
			bypass.r2InSel = prodCode;
	end

endmodule

//--- hdl/pipeCtrlTop.sv
/*
 * Control unit of the three-stage 8-bit pipeline. Ties the instruction
 * slots to the execute, writeback and bypass decoders.
 */
`timescale 1ns/1ps

module pipeCtrlTop #(
	parameter logic [1:0] oriReg = 2'd1 // register implied by ORI
) (
	input  logic                    clock,
	input  logic                    reset,
	input  pipeCtrlPkg::instr_t     fetchInstr,
	input  logic                    n,
	input  logic                    z,
	output pipeCtrlPkg::exCtrl_t    exCtrl,
	output logic                    pcSel,
	output pipeCtrlPkg::wbCtrl_t    wbCtrl,
	output pipeCtrlPkg::bypassSel_t bypass,
	output logic                    stopped
);

	pipeCtrlPkg::instr_t irRf; // register fetch slot
	pipeCtrlPkg::instr_t irEx; // execute slot
	pipeCtrlPkg::instr_t irWb; // writeback slot
	logic squash;              // taken branch kills the two younger slots

	instrPipe uPipe (
		.clock      (clock),
		.reset      (reset),
		.fetchInstr (fetchInstr),
		.squash     (squash),
		.stopped    (stopped),
		.irRf       (irRf),
		.irEx       (irEx),
		.irWb       (irWb)
	);

	executeDecode uExecute (
		.clock   (clock),
		.reset   (reset),
		.irEx    (irEx),
		.n       (n),
		.z       (z),
		.exCtrl  (exCtrl),
		.pcSel   (pcSel),
		.squash  (squash),
		.stopped (stopped)
	);

	writebackDecode uWriteback (
		.irWb   (irWb),
		.wbCtrl (wbCtrl)
	);

	bypassSelect #(
		.oriReg (oriReg)
	) uBypass (
		.irRf   (irRf),
		.irEx   (irEx),
		.irWb   (irWb),
		.bypass (bypass)
	);

endmodule

//--- sim/tbClock.sv
/*
 * Testbench clock and reset source. Reset is held for a number of cycles
 * at start and again whenever restart rises.
 */
`timescale 1ns/1ps

module tbClock #(
	parameter int periodNs    = 100,
	parameter int resetCycles = 16
) (
	input  logic restart, // request another reset pulse
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #(periodNs / 2) clock = ~clock;
	end

	// reset released on a falling edge, like the rest of the stimulus
	initial
	begin
		reset = 1'b1;
		forever
		begin
			repeat (resetCycles) @(posedge clock);
			@(negedge clock);
			reset = 1'b0;
			@(posedge restart);
			reset = 1'b1; // async into the dut
		end
	end

endmodule

//--- sim/pipeCtrlTb.sv
/*
 * Testbench for the pipeline control unit. Directed tests for decode,
 * bypass, branch squash and stop, checked against a local model.
 */
`timescale 1ns/1ps

module pipeCtrlTb;

	localparam logic [1:0] oriRegSet = 2'd2; // not the top-level default
	localparam logic [7:0] nopWord = pipeCtrlPkg::nopWord;

	// instruction kinds for the model
	localparam int kLoad = 0, kStore = 1, kAdd = 2, kSub = 3, kNand = 4, kShift = 5,
		kOri = 6, kBz = 7, kBnz = 8, kBpz = 9, kStop = 10, kOther = 11;

	logic clock;
	logic reset;
	logic restart;
	pipeCtrlPkg::instr_t     fetchInstr;
	logic                    n;
	logic                    z;
	pipeCtrlPkg::exCtrl_t    exCtrl;
	logic                    pcSel;
	pipeCtrlPkg::wbCtrl_t    wbCtrl;
	pipeCtrlPkg::bypassSel_t bypass;
	logic                    stopped;

	int seed;
	int errors;
	int checks;

	tbClock #(.periodNs(100), .resetCycles(16)) uClock (
		.restart (restart),
		.clock   (clock),
		.reset   (reset)
	);

	pipeCtrlTop #(.oriReg(oriRegSet)) uut (
		.clock      (clock),
		.reset      (reset),
		.fetchInstr (fetchInstr),
		.n          (n),
		.z          (z),
		.exCtrl     (exCtrl),
		.pcSel      (pcSel),
		.wbCtrl     (wbCtrl),
		.bypass     (bypass),
		.stopped    (stopped)
	);

	////////////////////////////////////////
	// instruction words
	function automatic logic [7:0] regWord(logic [3:0] op, logic [1:0] rx, logic [1:0] ry);
		return {rx, ry, op};
	endfunction

	function automatic logic [7:0] shiftWord(logic [1:0] rx, logic [2:0] amount);
		return {rx, amount, pipeCtrlPkg::opShift};
	endfunction

	function automatic logic [7:0] oriWord(logic [4:0] imm);
		return {imm, pipeCtrlPkg::opOri};
	endfunction

	function automatic logic [7:0] branchWord(logic [3:0] op, logic [3:0] offset);
		return {offset, op};
	endfunction

	////////////////////////////////////////
	// reference model
	function automatic int kindOf(logic [7:0] w);
		if (w[2:0] == pipeCtrlPkg::opOri)
			return kOri; // 3-bit opcodes first
		if (w[2:0] == pipeCtrlPkg::opShift)
			return kShift;
		case (w[3:0])
			pipeCtrlPkg::opLoad:  return kLoad;
			pipeCtrlPkg::opStore: return kStore;
			pipeCtrlPkg::opAdd:   return kAdd;
			pipeCtrlPkg::opSub:   return kSub;
			pipeCtrlPkg::opNand:  return kNand;
			pipeCtrlPkg::opBz:    return kBz;
			pipeCtrlPkg::opBnz:   return kBnz;
			pipeCtrlPkg::opBpz:   return kBpz;
			pipeCtrlPkg::opStop:  return kStop;
			default:              return kOther; // nop and unused codes
		endcase
	endfunction

	function automatic logic producesResult(logic [7:0] w);
		int k;
		k = kindOf(w);
		return (k == kAdd) || (k == kSub) || (k == kNand) || (k == kShift) ||
			(k == kOri) || (k == kLoad);
	endfunction

	function automatic logic [1:0] resultReg(logic [7:0] w);
		return (kindOf(w) == kOri) ? oriRegSet : w[7:6];
	endfunction

	// {used, register}
	function automatic logic [2:0] operandOne(logic [7:0] w);
		int k;
		k = kindOf(w);
		if (k == kOri)
			return {1'b1, oriRegSet};
		if ((k == kAdd) || (k == kSub) || (k == kNand) || (k == kShift) || (k == kStore))
			return {1'b1, w[7:6]};
		return 3'b000;
	endfunction

	function automatic logic [2:0] operandTwo(logic [7:0] w);
		int k;
		k = kindOf(w);
		if ((k == kAdd) || (k == kSub) || (k == kNand) || (k == kStore) || (k == kLoad))
			return {1'b1, w[5:4]};
		return 3'b000;
	endfunction

	function automatic pipeCtrlPkg::exCtrl_t exModel(logic [7:0] w);
		pipeCtrlPkg::exCtrl_t e;
		e = '0;
		case (kindOf(w))
			kLoad:
			begin
				e.memRead = 1'b1;
				e.mdrLoad = 1'b1;
			end
			kStore: e.memWrite = 1'b1;
			kAdd, kSub, kNand:
			begin
				e.flagWrite = 1'b1; // aluIn2Sel stays 0, register
				e.aluOp = (kindOf(w) == kAdd) ? pipeCtrlPkg::aluAdd :
					(kindOf(w) == kSub) ? pipeCtrlPkg::aluSub : pipeCtrlPkg::aluNand;
			end
			kShift:
			begin
				e.flagWrite = 1'b1;
				e.aluIn2Sel = 3'd4;
				e.aluOp     = pipeCtrlPkg::aluShift;
			end
			kOri:
			begin
				e.flagWrite = 1'b1;
				e.aluIn2Sel = 3'd3;
				e.aluOp     = pipeCtrlPkg::aluOri;
			end
			kBz, kBnz, kBpz:
			begin
				e.aluIn1Sel = 1'b1; // pc plus offset
				e.aluIn2Sel = 3'd2;
				e.aluOp     = pipeCtrlPkg::aluAdd;
			end
			default: e = '0;
		endcase
		return e;
	endfunction

	function automatic pipeCtrlPkg::wbCtrl_t wbModel(logic [7:0] w);
		pipeCtrlPkg::wbCtrl_t e;
		e.rfWrite = producesResult(w);
		e.regIn   = kindOf(w) == kLoad;
		e.rwSel   = kindOf(w) == kOri;
		return e;
	endfunction

	function automatic pipeCtrlPkg::bypassSel_t bypassModel(logic [7:0] rf, logic [7:0] ex,
		logic [7:0] wb);
		pipeCtrlPkg::bypassSel_t e;
		logic [1:0] code;
		logic [1:0] dest;
		logic [2:0] ex1;
		logic [2:0] ex2;
		logic [2:0] rf1;
		logic [2:0] rf2;
		int k;
		e = '0;
		if (!producesResult(wb))
			return e; // nothing to forward
		dest = resultReg(wb);
		code = (kindOf(wb) == kLoad) ? pipeCtrlPkg::bypMem : pipeCtrlPkg::bypAlu;
		ex1 = operandOne(ex);
		ex2 = operandTwo(ex);
		rf1 = operandOne(rf);
		rf2 = operandTwo(rf);
		k = kindOf(ex);
		if ((k == kAdd) || (k == kSub) || (k == kNand) || (k == kShift) || (k == kOri))
		begin
			if (ex1[2] && (ex1[1:0] == dest))
				e.aluIn1Sel = code;
			if (ex2[2] && (ex2[1:0] == dest))
				e.aluIn2Sel = code;
		end
		else if (k == kStore)
		begin
			if (ex1[2] && (ex1[1:0] == dest))
				e.memDataSel = code;
			if (ex2[2] && (ex2[1:0] == dest))
				e.memAddrSel = code;
		end
		else if ((k == kLoad) && ex2[2] && (ex2[1:0] == dest))
			e.memAddrSel = code;
		if (rf1[2] && (rf1[1:0] == dest))
			e.r1InSel = code;
		if (rf2[2] && (rf2[1:0] == dest))
			e.r2InSel = code;
		return e;
	endfunction

	function automatic logic branchTaken(logic [7:0] w, logic nv, logic zv);
		int k;
		k = kindOf(w);
		if (w[7:4] == 4'd0)
			return 1'b0; // offset zero is a halt, not a jump
		return ((k == kBz) && zv) || ((k == kBnz) && !zv) || ((k == kBpz) && !nv);
	endfunction

	////////////////////////////////////////
	// checks and helpers
	task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic quietOutputs(input logic stopExp);
		checkValue("exCtrl", 16'(exCtrl), 16'd0);
		checkValue("wbCtrl", 16'(wbCtrl), 16'd0);
		checkValue("bypass", 16'(bypass), 16'd0);
		checkValue("pcSel", 16'(pcSel), 16'd0);
		checkValue("stopped", 16'(stopped), 16'(stopExp));
	endtask

	// sampled on rising edges, reset only moves on falling ones
	task automatic waitResetRelease(input int limit, output logic ok);
		int count;
		ok = 1'b0;
		count = 0;
		while ((count < limit) && !ok)
		begin
			@(posedge clock);
			ok = !reset;
			count++;
		end
		if (!ok)
		begin
			errors++;
			$display("timeout: reset was still asserted after %0d cycles", limit);
		end
	endtask

	task automatic randomInstr(output logic [7:0] w);
		int r;
		int kind;
		r = $random(seed);
		kind = int'(r[23:16]) % 7;
		case (kind)
			0: w = regWord(pipeCtrlPkg::opAdd, r[1:0], r[3:2]);
			1: w = regWord(pipeCtrlPkg::opSub, r[1:0], r[3:2]);
			2: w = regWord(pipeCtrlPkg::opNand, r[1:0], r[3:2]);
			3: w = shiftWord(r[1:0], r[6:4]);
			4: w = oriWord(r[12:8]);
			5: w = regWord(pipeCtrlPkg::opLoad, r[1:0], r[3:2]);
			default: w = regWord(pipeCtrlPkg::opStore, r[1:0], r[3:2]);
		endcase
	endtask

	// producer then consumer back to back
	task automatic nearPair(input logic [7:0] prod, input logic [7:0] cons);
		@(negedge clock);
		fetchInstr = prod;
		@(negedge clock);
		fetchInstr = cons;
		@(negedge clock);
		fetchInstr = nopWord;
		@(negedge clock); // cons in irEx, prod in irWb
		checkValue("bypass", 16'(bypass), 16'(bypassModel(nopWord, cons, prod)));
	endtask

	task automatic farPair(input logic [7:0] prod, input logic [7:0] cons);
		pipeCtrlPkg::bypassSel_t exp;
		@(negedge clock);
		fetchInstr = prod;
		@(negedge clock);
		fetchInstr = nopWord;
		@(negedge clock);
		fetchInstr = cons;
		@(negedge clock); // cons in irRf
		exp = bypassModel(cons, nopWord, prod);
		checkValue("bypass.r1InSel", 16'(bypass.r1InSel), 16'(exp.r1InSel));
		checkValue("bypass.r2InSel", 16'(bypass.r2InSel), 16'(exp.r2InSel));
	endtask

	////////////////////////////////////////
	// directed tests
	task automatic resetState();
		@(negedge clock);
		quietOutputs(1'b0);
	endtask

	task automatic decodeEachOpcode();
		logic [7:0] words [12];
		int r;
		r = $random(seed);
		words[0]  = regWord(pipeCtrlPkg::opLoad, r[1:0], r[3:2]);
		words[1]  = regWord(pipeCtrlPkg::opStore, r[5:4], r[7:6]);
		words[2]  = regWord(pipeCtrlPkg::opAdd, r[9:8], r[11:10]);
		words[3]  = regWord(pipeCtrlPkg::opSub, r[13:12], r[15:14]);
		words[4]  = regWord(pipeCtrlPkg::opNand, r[17:16], r[19:18]);
		words[5]  = shiftWord(r[21:20], r[24:22]);
		words[6]  = oriWord(r[29:25]);
		words[7]  = branchWord(pipeCtrlPkg::opBz, 4'd3);
		words[8]  = branchWord(pipeCtrlPkg::opBnz, 4'd9);
		words[9]  = branchWord(pipeCtrlPkg::opBpz, 4'd15);
		words[10] = nopWord;
		words[11] = 8'hcc; // unused opcode
		n = 1'b0;
		z = 1'b0;
		for (int i = 0; i < 12; i++)
		begin
			@(negedge clock);
			fetchInstr = words[i];
			@(negedge clock);
			fetchInstr = nopWord;
			@(negedge clock);
			checkValue("exCtrl", 16'(exCtrl), 16'(exModel(words[i])));
			@(negedge clock);
			checkValue("wbCtrl", 16'(wbCtrl), 16'(wbModel(words[i])));
		end
	endtask

	task automatic bypassDistanceOne();
		logic [7:0] prod;
		logic [7:0] cons;
		nearPair(regWord(pipeCtrlPkg::opLoad, 2'd1, 2'd3), regWord(pipeCtrlPkg::opAdd, 2'd1, 2'd1));
		nearPair(oriWord(5'h0b), oriWord(5'h04)); // ori feeding ori
		nearPair(regWord(pipeCtrlPkg::opAdd, 2'd2, 2'd0), regWord(pipeCtrlPkg::opStore, 2'd2, 2'd2));
		nearPair(regWord(pipeCtrlPkg::opSub, 2'd0, 2'd1), regWord(pipeCtrlPkg::opLoad, 2'd3, 2'd0));
		for (int i = 0; i < 40; i++)
		begin
			randomInstr(prod);
			randomInstr(cons);
			nearPair(prod, cons);
		end
	endtask

	task automatic bypassDistanceTwo();
		logic [7:0] prod;
		logic [7:0] cons;
		farPair(regWord(pipeCtrlPkg::opLoad, 2'd3, 2'd0), shiftWord(2'd3, 3'd5));
		farPair(regWord(pipeCtrlPkg::opNand, 2'd0, 2'd1), regWord(pipeCtrlPkg::opStore, 2'd0, 2'd0));
		for (int i = 0; i < 40; i++)
		begin
			randomInstr(prod);
			randomInstr(cons);
			farPair(prod, cons);
		end
	endtask

	task automatic branchResolution();
		logic [3:0] ops [3];
		logic [7:0] br;
		logic [7:0] f1;
		logic [7:0] f2;
		logic [3:0] off;
		logic taken;
		int r;
		ops[0] = pipeCtrlPkg::opBz;
		ops[1] = pipeCtrlPkg::opBnz;
		ops[2] = pipeCtrlPkg::opBpz;
		for (int i = 0; i < 12; i++)
		begin
			r = $random(seed);
			off = r[3:0];
			if (off == 4'd0)
				off = 4'd7; // keep it a real jump
			br = branchWord(ops[i / 4], off);
			f1 = regWord(pipeCtrlPkg::opAdd, r[5:4], r[7:6]);
			f2 = regWord(pipeCtrlPkg::opLoad, r[9:8], r[11:10]);
			taken = branchTaken(br, i[1], i[0]);
			@(negedge clock);
			fetchInstr = br;
			n = i[1];
			z = i[0];
			@(negedge clock);
			fetchInstr = f1;
			@(negedge clock); // branch in irEx
			checkValue("pcSel", 16'(pcSel), 16'(taken));
			fetchInstr = f2;
			@(negedge clock);
			checkValue("pcSel", 16'(pcSel), 16'd0);
			checkValue("exCtrl", 16'(exCtrl), taken ? 16'd0 : 16'(exModel(f1)));
			fetchInstr = nopWord;
			@(negedge clock);
			checkValue("exCtrl", 16'(exCtrl), taken ? 16'd0 : 16'(exModel(f2)));
			checkValue("wbCtrl", 16'(wbCtrl), taken ? 16'd0 : 16'(wbModel(f1)));
			@(negedge clock);
			checkValue("wbCtrl", 16'(wbCtrl), taken ? 16'd0 : 16'(wbModel(f2)));
		end
	endtask

	task automatic stopAndRestart(input logic [7:0] haltWord);
		logic [7:0] w;
		logic ok;
		@(negedge clock);
		fetchInstr = haltWord;
		n = 1'b0;
		z = 1'b1; // would satisfy bz, offset zero wins
		@(negedge clock);
		fetchInstr = regWord(pipeCtrlPkg::opAdd, 2'd1, 2'd2);
		@(negedge clock); // halt word in irEx
		checkValue("stopped", 16'(stopped), 16'd0);
		checkValue("pcSel", 16'(pcSel), 16'd0);
		fetchInstr = regWord(pipeCtrlPkg::opLoad, 2'd1, 2'd1);
		@(negedge clock);
		for (int i = 0; i < 8; i++)
		begin
			quietOutputs(1'b1);
			randomInstr(w);
			fetchInstr = w;
			@(negedge clock);
		end
		restart = 1'b1;
		fetchInstr = nopWord;
		@(negedge clock);
		restart = 1'b0;
		checkValue("stopped", 16'(stopped), 16'd0); // cleared by async reset
		waitResetRelease(40, ok);
		if (!ok)
			return;
		@(negedge clock);
		quietOutputs(1'b0);
	endtask

	////////////////////////////////////////
	// main sequence
	initial
	begin
		logic ok;
		seed = 12906;
		errors = 0;
		checks = 0;
		restart = 1'b0;
		fetchInstr = nopWord;
		n = 1'b0;
		z = 1'b0;
		waitResetRelease(40, ok);
		if (ok)
		begin
			resetState();
			decodeEachOpcode();
			bypassDistanceOne();
			bypassDistanceTwo();
			branchResolution();
			stopAndRestart(regWord(pipeCtrlPkg::opStop, 2'd3, 2'd1));
			stopAndRestart(branchWord(pipeCtrlPkg::opBz, 4'd0));
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- build.f
common/pipeCtrlPkg.sv
hdl/instrPipe.sv
execute/executeDecode.sv
hdl/writebackDecode.sv
hazard/bypassSelect.sv
hdl/pipeCtrlTop.sv
sim/tbClock.sv
sim/pipeCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module pipeCtrlTb \
	-f build.f -o pipeCtrlSim \
	&& ./obj_dir/pipeCtrlSim | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
